/* mul_macros.svh */
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// Data word and product widths
`define MUL_XLEN             32
`define MUL_PROD_W           66
`define MUL_CLMUL_W          63

// Control field width for grev and gorc
`define MUL_SHAMT_W          5

// Reflected CRC polynomials
`define MUL_CRC32_POLY_REV   32'hEDB88320
`define MUL_CRC32C_POLY_REV  32'h82F63B78

// Extension group enables, 1 keeps the group
`define MUL_EN_ZBC           1
`define MUL_EN_ZBP           1
`define MUL_EN_ZBR           1

`endif

/* mul_pkg.sv */
`include "mul_macros.svh"

package mul_pkg;

   typedef logic [`MUL_XLEN-1:0] word_t;

   // Operation flags; none of the function flags set selects a multiply
   typedef struct packed {
      logic valid;
      logic rs1_sign;
      logic rs2_sign;
      logic low;
      logic clmul;
      logic clmulh;
      logic clmulr;
      logic grev;
      logic gorc;
      logic crc32_b;
      logic crc32_h;
      logic crc32_w;
      logic crc32c_b;
      logic crc32c_h;
      logic crc32c_w;
   } mul_op_t;

   // Execute stage multiply operands, already sign extended to 33 bits
   typedef struct packed {
      logic                    low;
      logic signed [`MUL_XLEN:0] rs1_ext;
      logic signed [`MUL_XLEN:0] rs2_ext;
   } mul_opnd_t;

   // Execute stage bit-manip result
   typedef struct packed {
      logic  sel;
      word_t data;
   } bitmanip_res_t;

endpackage

/* mul_operand_stage.sv */
`include "mul_macros.svh"

module mul_operand_stage (
   input  logic               clk,
   input  logic               rst_i,
   input  mul_pkg::mul_op_t   op_i,
   input  mul_pkg::word_t     rs1_i,
   input  mul_pkg::word_t     rs2_i,
   output mul_pkg::mul_opnd_t opnd_o
);

   mul_pkg::mul_opnd_t opnd_d;

   // Top bit is the sign only for a signed operand
   always_comb
   begin
      opnd_d.low     = op_i.low;
      opnd_d.rs1_ext = {op_i.rs1_sign & rs1_i[`MUL_XLEN-1], rs1_i};
      opnd_d.rs2_ext = {op_i.rs2_sign & rs2_i[`MUL_XLEN-1], rs2_i};
   end

   // Loads only on a valid operation, holds otherwise
   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         opnd_o <= '0;
      end
      else if (op_i.valid)
      begin
         opnd_o <= opnd_d;
      end
   end

endmodule

/* bitmanip_perm.sv */
`include "mul_macros.svh"

module bitmanip_perm (
   input  mul_pkg::word_t rs1_i,
   input  mul_pkg::word_t rs2_i,
   output mul_pkg::word_t grev_o,
   output mul_pkg::word_t gorc_o
);

   // Value entering each butterfly stage, last entry is the result
   logic [`MUL_SHAMT_W:0][`MUL_XLEN-1:0] grev_s;
   logic [`MUL_SHAMT_W:0][`MUL_XLEN-1:0] gorc_s;

   assign grev_s[0] = rs1_i;
   assign gorc_s[0] = rs1_i;

   genvar k;
   genvar b;

   for (k = 0; k < `MUL_SHAMT_W; k++)
   begin : g_stage
      logic [`MUL_XLEN-1:0] grev_swp;
      logic [`MUL_XLEN-1:0] gorc_swp;

      // Bit b pairs with bit b xor stride, stride is 2**k
      for (b = 0; b < `MUL_XLEN; b++)
      begin : g_bit
         assign grev_swp[b] = grev_s[k][b ^ (1 << k)];
         assign gorc_swp[b] = gorc_s[k][b ^ (1 << k)];
      end

      assign grev_s[k+1] = rs2_i[k] ? grev_swp : grev_s[k];
      assign gorc_s[k+1] = gorc_s[k] | ({`MUL_XLEN{rs2_i[k]}} & gorc_swp);
   end

   assign grev_o = grev_s[`MUL_SHAMT_W];
   assign gorc_o = gorc_s[`MUL_SHAMT_W];

endmodule

/* bitmanip_clmul.sv */
`include "mul_macros.svh"

module bitmanip_clmul (
   input  mul_pkg::word_t          rs1_i,
   input  mul_pkg::word_t          rs2_i,
   output logic [`MUL_CLMUL_W-1:0] clmul_o
);

   // Running XOR of the partial products, entry i holds terms 0 to i-1
   logic [`MUL_XLEN:0][`MUL_CLMUL_W-1:0] acc;
   logic [`MUL_CLMUL_W-1:0]              rs1_wide;

   assign rs1_wide = {{(`MUL_CLMUL_W-`MUL_XLEN){1'b0}}, rs1_i};
   assign acc[0]   = '0;

   genvar i;

   for (i = 0; i < `MUL_XLEN; i++)
   begin : g_term
      logic [`MUL_CLMUL_W-1:0] term;

      assign term     = {`MUL_CLMUL_W{rs2_i[i]}} & (rs1_wide << i);
      assign acc[i+1] = acc[i] ^ term;
   end

   assign clmul_o = acc[`MUL_XLEN];

endmodule

/* bitmanip_crc.sv */
`include "mul_macros.svh"

module bitmanip_crc (
   input  mul_pkg::word_t rs1_i,
   output mul_pkg::word_t crc32_b_o,
   output mul_pkg::word_t crc32_h_o,
   output mul_pkg::word_t crc32_w_o,
   output mul_pkg::word_t crc32c_b_o,
   output mul_pkg::word_t crc32c_h_o,
   output mul_pkg::word_t crc32c_w_o
);

   // Reflected LFSR, one shift per input bit
   function automatic mul_pkg::word_t crc_reduce(
      input mul_pkg::word_t data,
      input mul_pkg::word_t poly,
      input int unsigned    steps
   );
      mul_pkg::word_t crc;

      crc = data;
      for (int i = 0; i < `MUL_XLEN; i++)
      begin
         // Fixed trip count so the loop unrolls to a constant depth
         if (i < steps)
         begin
            crc = (crc >> 1) ^ (poly & {`MUL_XLEN{crc[0]}});
         end
      end
      return crc;
   endfunction

   localparam mul_pkg::word_t poly_crc32  = `MUL_CRC32_POLY_REV;
   localparam mul_pkg::word_t poly_crc32c = `MUL_CRC32C_POLY_REV;

   // Byte, halfword and word forms
   assign crc32_b_o  = crc_reduce(rs1_i, poly_crc32, 8);
   assign crc32_h_o  = crc_reduce(rs1_i, poly_crc32, 16);
   assign crc32_w_o  = crc_reduce(rs1_i, poly_crc32, 32);

   // Castagnoli variants
   assign crc32c_b_o = crc_reduce(rs1_i, poly_crc32c, 8);
   assign crc32c_h_o = crc_reduce(rs1_i, poly_crc32c, 16);
   assign crc32c_w_o = crc_reduce(rs1_i, poly_crc32c, 32);

endmodule

/* bitmanip_stage.sv */
`include "mul_macros.svh"

module bitmanip_stage (
   input  logic                   clk,
   input  logic                   rst_i,
   input  mul_pkg::mul_op_t       op_i,
   input  mul_pkg::word_t         grev_i,
   input  mul_pkg::word_t         gorc_i,
   input  mul_pkg::word_t         crc32_b_i,
   input  mul_pkg::word_t         crc32_h_i,
   input  mul_pkg::word_t         crc32_w_i,
   input  mul_pkg::word_t         crc32c_b_i,
   input  mul_pkg::word_t         crc32c_h_i,
   input  mul_pkg::word_t         crc32c_w_i,
   input  logic [`MUL_CLMUL_W-1:0] clmul_i,
   output mul_pkg::bitmanip_res_t bm_o
);

   localparam bit en_zbc = (`MUL_EN_ZBC != 0);
   localparam bit en_zbp = (`MUL_EN_ZBP != 0);
   localparam bit en_zbr = (`MUL_EN_ZBR != 0);

   mul_pkg::mul_op_t       ap;
   mul_pkg::bitmanip_res_t bm_d;

   // Flags of a disabled group fall back to a plain multiply
   always_comb
   begin
      ap          = op_i;
      ap.clmul    = op_i.clmul & en_zbc;
      ap.clmulh   = op_i.clmulh & en_zbc;
      ap.clmulr   = op_i.clmulr & en_zbc;
      ap.grev     = op_i.grev & en_zbp;
      ap.gorc     = op_i.gorc & en_zbp;
      ap.crc32_b  = op_i.crc32_b & en_zbr;
      ap.crc32_h  = op_i.crc32_h & en_zbr;
      ap.crc32_w  = op_i.crc32_w & en_zbr;
      ap.crc32c_b = op_i.crc32c_b & en_zbr;
      ap.crc32c_h = op_i.crc32c_h & en_zbr;
      ap.crc32c_w = op_i.crc32c_w & en_zbr;
   end

   // One-hot AND-OR select, at most one flag is set
   always_comb
   begin
      bm_d.sel  = ap.clmul | ap.clmulh | ap.clmulr | ap.grev | ap.gorc |
                  ap.crc32_b | ap.crc32_h | ap.crc32_w |
                  ap.crc32c_b | ap.crc32c_h | ap.crc32c_w;
      bm_d.data = ({`MUL_XLEN{ap.clmul}}    & clmul_i[`MUL_XLEN-1:0]) |
                  ({`MUL_XLEN{ap.clmulh}}   & {1'b0, clmul_i[`MUL_CLMUL_W-1:`MUL_XLEN]}) |
                  ({`MUL_XLEN{ap.clmulr}}   & clmul_i[`MUL_CLMUL_W-1:`MUL_XLEN-1]) |
                  ({`MUL_XLEN{ap.grev}}     & grev_i) |
                  ({`MUL_XLEN{ap.gorc}}     & gorc_i) |
                  ({`MUL_XLEN{ap.crc32_b}}  & crc32_b_i) |
                  ({`MUL_XLEN{ap.crc32_h}}  & crc32_h_i) |
                  ({`MUL_XLEN{ap.crc32_w}}  & crc32_w_i) |
                  ({`MUL_XLEN{ap.crc32c_b}} & crc32c_b_i) |
                  ({`MUL_XLEN{ap.crc32c_h}} & crc32c_h_i) |
                  ({`MUL_XLEN{ap.crc32c_w}} & crc32c_w_i);
   end

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         bm_o <= '0;
      end
      else if (op_i.valid)
      begin
         bm_o <= bm_d;
      end
   end

endmodule

/* mul_result_stage.sv */
`include "mul_macros.svh"

module mul_result_stage (
   input  mul_pkg::mul_opnd_t     opnd_i,
   input  mul_pkg::bitmanip_res_t bm_i,
   output mul_pkg::word_t         result_o
);

   // Full signed product of the two 33-bit operands
   logic signed [`MUL_PROD_W-1:0] prod;

   assign prod = $signed(opnd_i.rs1_ext) * $signed(opnd_i.rs2_ext);

   // Bit-manip result wins over either product word
   always_comb
   begin
      if (bm_i.sel)
      begin
         result_o = bm_i.data;
      end
      else if (opnd_i.low)
      begin
         result_o = prod[`MUL_XLEN-1:0];
      end
      else
      begin
         // MULH, MULHSU and MULHU all take the upper word
         result_o = prod[2*`MUL_XLEN-1:`MUL_XLEN];
      end
   end

endmodule

/* mul_bitmanip_top.sv */
`include "mul_macros.svh"

module mul_bitmanip_top (
   input  logic             clk,
   input  logic             rst_i,
   input  mul_pkg::mul_op_t op_i,
   input  mul_pkg::word_t   rs1_i,
   input  mul_pkg::word_t   rs2_i,
   output mul_pkg::word_t   result_o
);

   mul_pkg::mul_opnd_t      opnd;
   mul_pkg::bitmanip_res_t  bm;
   mul_pkg::word_t          grev;
   mul_pkg::word_t          gorc;
   logic [`MUL_CLMUL_W-1:0] clmul;
   mul_pkg::word_t          crc32_b;
   mul_pkg::word_t          crc32_h;
   mul_pkg::word_t          crc32_w;
   mul_pkg::word_t          crc32c_b;
   mul_pkg::word_t          crc32c_h;
   mul_pkg::word_t          crc32c_w;

   // Decode stage
   mul_operand_stage u_operand_stage (
      .clk    (clk),
      .rst_i  (rst_i),
      .op_i   (op_i),
      .rs1_i  (rs1_i),
      .rs2_i  (rs2_i),
      .opnd_o (opnd)
   );

   bitmanip_perm u_perm (
      .rs1_i  (rs1_i),
      .rs2_i  (rs2_i),
      .grev_o (grev),
      .gorc_o (gorc)
   );

   bitmanip_clmul u_clmul (
      .rs1_i   (rs1_i),
      .rs2_i   (rs2_i),
      .clmul_o (clmul)
   );

   bitmanip_crc u_crc (
      .rs1_i      (rs1_i),
      .crc32_b_o  (crc32_b),
      .crc32_h_o  (crc32_h),
      .crc32_w_o  (crc32_w),
      .crc32c_b_o (crc32c_b),
      .crc32c_h_o (crc32c_h),
      .crc32c_w_o (crc32c_w)
   );

   bitmanip_stage u_bitmanip_stage (
      .clk        (clk),
      .rst_i      (rst_i),
      .op_i       (op_i),
      .grev_i     (grev),
      .gorc_i     (gorc),
      .crc32_b_i  (crc32_b),
      .crc32_h_i  (crc32_h),
      .crc32_w_i  (crc32_w),
      .crc32c_b_i (crc32c_b),
      .crc32c_h_i (crc32c_h),
      .crc32c_w_i (crc32c_w),
      .clmul_i    (clmul),
      .bm_o       (bm)
   );

   // Execute stage
   mul_result_stage u_result_stage (
      .opnd_i   (opnd),
      .bm_i     (bm),
      .result_o (result_o)
   );

endmodule

/* tb_mul_bitmanip_asserts.sv */
`include "mul_macros.svh"

module mul_bitmanip_asserts (
   input logic             clk,
   input logic             rst_i,
   input mul_pkg::mul_op_t op_i,
   input mul_pkg::word_t   rs1_i,
   input mul_pkg::word_t   rs2_i,
   input mul_pkg::word_t   result_i
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned      fail_count = 0;
   logic             started    = 1'b0;
   logic             seen_valid = 1'b0;
   logic             chk_q      = 1'b0;
   logic             hold_q     = 1'b0;
   mul_pkg::word_t   prev_q;
   mul_pkg::mul_op_t op_q;
   mul_pkg::word_t   a_q;
   mul_pkg::word_t   b_q;

   // Shift-and-add over the 66-bit product
   function automatic mul_pkg::word_t ref_mul(input mul_pkg::mul_op_t op,
                                              input mul_pkg::word_t a, input mul_pkg::word_t b);
      logic [`MUL_PROD_W-1:0] a_w;
      logic [`MUL_PROD_W-1:0] acc;
      a_w = {{(`MUL_PROD_W-`MUL_XLEN){op.rs1_sign & a[`MUL_XLEN-1]}}, a};
      acc = '0;
      for (int i = 0; i < `MUL_XLEN; i++)
         if (b[i])
            acc = acc + (a_w << i);
      // Sign bit of a signed b weighs minus 2**32
      if (op.rs2_sign && b[`MUL_XLEN-1])
         acc = acc - (a_w << `MUL_XLEN);
      return op.low ? acc[`MUL_XLEN-1:0] : acc[2*`MUL_XLEN-1:`MUL_XLEN];
   endfunction

   function automatic mul_pkg::word_t ref_clmul(input mul_pkg::mul_op_t op,
                                                input mul_pkg::word_t a, input mul_pkg::word_t b);
      logic [`MUL_CLMUL_W-1:0] r;
      r = '0;
      for (int i = 0; i < `MUL_XLEN; i++)
         for (int j = 0; j < `MUL_XLEN; j++)
            r[i+j] = r[i+j] ^ (a[i] & b[j]);
      if (op.clmulh)
         return {1'b0, r[`MUL_CLMUL_W-1:`MUL_XLEN]};
      if (op.clmulr)
         return r[`MUL_CLMUL_W-1:`MUL_XLEN-1];
      return r[`MUL_XLEN-1:0];
   endfunction

   // Mask-and-shift butterfly, or_mode keeps the stage input
   function automatic mul_pkg::word_t ref_perm(input mul_pkg::word_t x,
                                               input logic [`MUL_SHAMT_W-1:0] ctl, input logic or_mode);
      mul_pkg::word_t m [5];
      mul_pkg::word_t s;
      m = '{32'h55555555, 32'h33333333, 32'h0F0F0F0F, 32'h00FF00FF, 32'h0000FFFF};
      for (int k = 0; k < `MUL_SHAMT_W; k++)
         if (ctl[k])
         begin
            s = ((x & m[k]) << (1 << k)) | ((x & ~m[k]) >> (1 << k));
            x = or_mode ? (x | s) : s;
         end
      return x;
   endfunction

   function automatic mul_pkg::word_t ref_crc(input mul_pkg::word_t x,
                                              input mul_pkg::word_t poly, input int steps);
      logic out_bit;
      for (int i = 0; i < steps; i++)
      begin
         out_bit = x[0];
         x       = x >> 1;
         if (out_bit)
            x = x ^ poly;
      end
      return x;
   endfunction

   function automatic mul_pkg::word_t expected(input mul_pkg::mul_op_t op,
                                               input mul_pkg::word_t a, input mul_pkg::word_t b);
      logic crc_c;
      int   steps;
      crc_c = op.crc32c_b | op.crc32c_h | op.crc32c_w;
      steps = (op.crc32_b | op.crc32c_b) ? 8 : (op.crc32_h | op.crc32c_h) ? 16 : 32;
      if (op.clmul | op.clmulh | op.clmulr)
         return ref_clmul(op, a, b);
      if (op.grev | op.gorc)
         return ref_perm(a, b[`MUL_SHAMT_W-1:0], op.gorc);
      if (op.crc32_b | op.crc32_h | op.crc32_w | crc_c)
         return ref_crc(a, crc_c ? `MUL_CRC32C_POLY_REV : `MUL_CRC32_POLY_REV, steps);
      return ref_mul(op, a, b);
   endfunction

   function automatic string op_name(input mul_pkg::mul_op_t op);
      if (op.clmul | op.clmulh | op.clmulr)
         return "clmul";
      if (op.grev | op.gorc)
         return "perm";
      if (op.crc32_b | op.crc32_h | op.crc32_w | op.crc32c_b | op.crc32c_h | op.crc32c_w)
         return "crc";
      return "mul";
   endfunction

   // Operation captured on the accepting edge, checked one edge later
   always @(posedge clk)
   begin
      started <= 1'b1;
      chk_q   <= !rst_i && op_i.valid;
      hold_q  <= !rst_i && !op_i.valid;
      prev_q  <= result_i;
      if (rst_i)
         seen_valid <= 1'b0;
      else if (op_i.valid)
      begin
         seen_valid <= 1'b1;
         op_q       <= op_i;
         a_q        <= rs1_i;
         b_q        <= rs2_i;
      end
   end

   a_reset: assert property (@(posedge clk) (started && !seen_valid) |-> result_i == '0)
      else
      begin
         $error("Fail reset: expected %h, actual %h", 32'h0, $sampled(result_i));
         fail_count++;
      end

   a_result: assert property (@(posedge clk) chk_q |-> result_i == expected(op_q, a_q, b_q))
      else
      begin
         $error("Fail %s: expected %h, actual %h", op_name($sampled(op_q)),
                expected($sampled(op_q), $sampled(a_q), $sampled(b_q)), $sampled(result_i));
         fail_count++;
      end

   // Published byte vectors for both CRC polynomials
   a_crc_known: assert property (@(posedge clk)
         (chk_q && (op_q.crc32_b | op_q.crc32c_b) && a_q == 32'hFFFFFF9E)
         |-> result_i == (op_q.crc32_b ? 32'h174841BC : 32'h3E2FBCCF))
      else
      begin
         $error("Fail crc_known: expected %h, actual %h",
                $sampled(op_q.crc32_b) ? 32'h174841BC : 32'h3E2FBCCF, $sampled(result_i));
         fail_count++;
      end

   a_hold: assert property (@(posedge clk) hold_q |-> result_i == prev_q)
      else
      begin
         $error("Fail hold: expected %h, actual %h", $sampled(prev_q), $sampled(result_i));
         fail_count++;
      end

endmodule

bind mul_bitmanip_top mul_bitmanip_asserts u_asserts (
   .clk      (clk),
   .rst_i    (rst_i),
   .op_i     (op_i),
   .rs1_i    (rs1_i),
   .rs2_i    (rs2_i),
   .result_i (result_o)
);

/* tb_mul_bitmanip.sv */
module tb_mul_bitmanip;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYCLES = 10;
   localparam int NUM_TESTS    = 6;
   localparam int OPS_PER_TEST = 300;
   // Reset and six tests at one cycle per operation plus margin
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_TESTS * OPS_PER_TEST + 390;

   logic             clk;
   logic             rst_i;
   mul_pkg::mul_op_t op_i;
   mul_pkg::word_t   rs1_i;
   mul_pkg::word_t   rs2_i;
   mul_pkg::word_t   result_o;
   logic [31:0]      lfsr_state;
   int unsigned      cycle_count;

   mul_bitmanip_top dut0 (
      .clk      (clk),
      .rst_i    (rst_i),
      .op_i     (op_i),
      .rs1_i    (rs1_i),
      .rs2_i    (rs2_i),
      .result_o (result_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Galois LFSR stepped once per bit taken
   function automatic logic lfsr_bit();
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
      return lfsr_state[0];
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], lfsr_bit()};
      return v;
   endfunction

   // Corners in about three draws of eight
   function automatic mul_pkg::word_t pick_operand();
      case (random_bits(3))
         0: return 32'h80000000;
         1: return 32'hFFFFFFFF;
         2: return 32'h0;
         default: return random_bits(32);
      endcase
   endfunction

   task automatic issue(input mul_pkg::mul_op_t op, input mul_pkg::word_t a,
                        input mul_pkg::word_t b);
      @(posedge clk);
      op_i  <= op;
      rs1_i <= a;
      rs2_i <= b;
   endtask

   // Test 0 mul, 1 clmul, 2 grev and gorc, 3 CRC, 4 mixed, 5 mixed with sparse valid
   task automatic random_op(input int test_id, output mul_pkg::mul_op_t op,
                            output mul_pkg::word_t a, output mul_pkg::word_t b);
      int flag;
      op          = '0;
      op.valid    = (test_id == 5) ? (random_bits(2) == 0) : lfsr_bit();
      op.rs1_sign = lfsr_bit();
      op.rs2_sign = lfsr_bit();
      op.low      = lfsr_bit();
      case (test_id)
         0: flag = -1;
         1: flag = int'(random_bits(2) % 3);
         2: flag = 3 + int'(random_bits(1));
         3: flag = 5 + int'(random_bits(3) % 6);
         default: flag = int'(random_bits(4) % 12) - 1;
      endcase
      // Function flags sit at bits 10 down to 0 with clmul first
      if (flag >= 0)
         op[10 - flag] = 1'b1;
      a = pick_operand();
      b = pick_operand();
      if (test_id == 2 && random_bits(2) == 0)
         b = 32'd31;
   endtask

   task automatic directed_ops(input int test_id);
      mul_pkg::mul_op_t op;
      op       = '0;
      op.valid = 1'b1;
      if (test_id == 2)
      begin
         // Full bit reversal
         op.grev = 1'b1;
         issue(op, random_bits(32), 32'd31);
      end
      else if (test_id == 3)
      begin
         op.crc32_b = 1'b1;
         issue(op, 32'hFFFFFF9E, 32'h0);
         op.crc32_b  = 1'b0;
         op.crc32c_b = 1'b1;
         issue(op, 32'hFFFFFF9E, 32'h0);
      end
   endtask

   initial
   begin
      mul_pkg::mul_op_t op;
      mul_pkg::word_t   a;
      mul_pkg::word_t   b;
      rst_i       = 1'b1;
      op_i        = '0;
      rs1_i       = '0;
      rs2_i       = '0;
      lfsr_state  = 32'd74592;
      cycle_count = 0;
      // Valid operations under reset must leave the result at zero
      for (int n = 0; n < RESET_CYCLES - 1; n++)
      begin
         random_op(4, op, a, b);
         op.valid = 1'b1;
         issue(op, a, b);
      end
      @(posedge clk);
      rst_i <= 1'b0;
      op_i  <= '0;
      for (int t = 0; t < NUM_TESTS; t++)
      begin
         directed_ops(t);
         for (int n = 0; n < OPS_PER_TEST; n++)
         begin
            random_op(t, op, a, b);
            issue(op, a, b);
         end
      end
      // Drain so the last operation is checked
      issue('0, '0, '0);
      repeat (3) @(posedge clk);
      if (dut0.u_asserts.fail_count == 0)
      begin
         $display("TESTS PASSED");
         $finish;
      end
      else
      begin
         $display("TESTS FAILED");
         $fatal(1, "The checker counted %0d failures", dut0.u_asserts.fail_count);
      end
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("TESTS FAILED");
         $fatal(1, "Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      end
      else if (dut0.u_asserts.fail_count != 0)
      begin
         $display("TESTS FAILED");
         $fatal(1, "A checker assertion failed, stopping at the first error");
      end
   end

endmodule

/* list.f */
+incdir+.
mul_pkg.sv
mul_operand_stage.sv
bitmanip_perm.sv
bitmanip_clmul.sv
bitmanip_crc.sv
bitmanip_stage.sv
mul_result_stage.sv
mul_bitmanip_top.sv
tb_mul_bitmanip_asserts.sv
tb_mul_bitmanip.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the multiply and bit-manip testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_mul_bitmanip -f list.f -o tb_mul_bitmanip

status=0
./obj_dir/tb_mul_bitmanip +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log || [ "$status" -ne 0 ]; then
   echo "Simulation reported a failure"
   exit 1
fi
echo "Simulation finished without failures"
